/* src/spm_cfg_pkg.sv */
package spm_cfg_pkg;

    // scratchpad geometry
    // 64 words of 32 bits each
    localparam int unsigned spm_words  = 64;
    localparam int unsigned spm_addr_w = $clog2(spm_words);
    localparam int unsigned spm_data_w = 32;

    // load tag, returned unchanged with the load data
    localparam int unsigned spm_tag_w = 4;

    // queue depths
    localparam int unsigned req_depth = 4;
    // kept small so response back-pressure shows up quickly
    localparam int unsigned rsp_depth = 2;

    // width of the response fifo usage value
    // same derivation as the address width inside fifo_v3
    localparam int unsigned rsp_cnt_w = (rsp_depth > 1) ? $clog2(rsp_depth) : 1;

endpackage

/* src/spm_types_pkg.sv */
package spm_types_pkg;

    import spm_cfg_pkg::*;

    // request kind
    typedef enum logic {
        op_load  = 1'b0,
        op_store = 1'b1
    } spm_op_e;

    // load view of the payload word
    // only the low bits carry the tag, the rest is unused
    typedef struct packed {
        logic [spm_data_w-spm_tag_w-1:0] rsvd;
        logic [spm_tag_w-1:0]            tag;
    } spm_load_pl_t;

    // one payload word, read two ways depending on the opcode
    // store: write data
    // load: tag plus reserved bits
    typedef union packed {
        logic [spm_data_w-1:0] wdata;
        spm_load_pl_t          ld;
    } spm_payload_u;

    // request as it travels through the request fifo, 39 bits
    typedef struct packed {
        spm_op_e                op;
        logic [spm_addr_w-1:0]  addr;
        spm_payload_u           payload;
    } spm_req_t;

    // load result, 36 bits
    typedef struct packed {
        logic [spm_tag_w-1:0]   tag;
        logic [spm_data_w-1:0]  data;
    } spm_rsp_t;

endpackage

/* src/fifo_v3.sv */
module fifo_v3 #(
    // forward data_i to data_o when the queue is empty
    parameter bit          FALL_THROUGH = 1'b0,
    // number of entries, at least one
    parameter int unsigned DEPTH        = 8,
    // entry type
    parameter type         dtype        = logic,
    // derived, not meant to be overridden
    localparam int unsigned ADDR_DEPTH  = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  flush_i,
    // status levels
    output logic                  full_o,
    output logic                  empty_o,
    output logic [ADDR_DEPTH-1:0] usage_o,
    // write side
    input  dtype                  data_i,
    input  logic                  push_i,
    // read side
    output dtype                  data_o,
    input  logic                  pop_i
);

    // last valid pointer value, wrap back to zero after it
    localparam logic [ADDR_DEPTH-1:0] ptr_last = ADDR_DEPTH'(DEPTH - 1);
    // count value when every slot holds data
    localparam logic [ADDR_DEPTH:0]   cnt_full = (ADDR_DEPTH + 1)'(DEPTH);

    // read and write pointers
    logic [ADDR_DEPTH-1:0] rd_ptr_d;
    logic [ADDR_DEPTH-1:0] rd_ptr_q;
    logic [ADDR_DEPTH-1:0] wr_ptr_d;
    logic [ADDR_DEPTH-1:0] wr_ptr_q;

    // occupancy, one bit wider than the pointers so full is visible
    logic [ADDR_DEPTH:0]   cnt_d;
    logic [ADDR_DEPTH:0]   cnt_q;

    // storage, written only on an accepted push
    dtype                  mem_q [DEPTH];
    logic                  mem_we;

    // low bits of the count, wraps to zero when full
    assign usage_o = cnt_q[ADDR_DEPTH-1:0];

    assign full_o  = (cnt_q == cnt_full);
    // in fall-through mode an incoming push makes the queue look non-empty
    assign empty_o = (cnt_q == '0) && !(FALL_THROUGH && push_i);

    always_comb begin
        rd_ptr_d = rd_ptr_q;
        wr_ptr_d = wr_ptr_q;
        cnt_d    = cnt_q;
        mem_we   = 1'b0;
        // head of the queue by default
        data_o   = mem_q[rd_ptr_q];

        // accepted push: store at the write pointer and advance it
        if (push_i && !full_o) begin
            mem_we = 1'b1;
            if (wr_ptr_q == ptr_last) begin
                wr_ptr_d = '0;
            end else begin
                wr_ptr_d = wr_ptr_q + 1'b1;
            end
            cnt_d = cnt_d + 1'b1;
        end

        // accepted pop: advance the read pointer
        // count is taken from cnt_d so push plus pop cancels out
        if (pop_i && !empty_o) begin
            if (rd_ptr_q == ptr_last) begin
                rd_ptr_d = '0;
            end else begin
                rd_ptr_d = rd_ptr_q + 1'b1;
            end
            cnt_d = cnt_d - 1'b1;
        end

        // empty queue in fall-through mode
        // incoming word goes straight to the output
        if (FALL_THROUGH && (cnt_q == '0) && push_i) begin
            data_o = data_i;
            // consumed in the same cycle, so nothing is queued
            if (pop_i) begin
                rd_ptr_d = rd_ptr_q;
                wr_ptr_d = wr_ptr_q;
                cnt_d    = cnt_q;
            end
        end
    end

    // pointer and count registers
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (flush_i) begin
            // flush drops every entry, contents are left as they are
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            rd_ptr_q <= rd_ptr_d;
            wr_ptr_q <= wr_ptr_d;
            cnt_q    <= cnt_d;
        end
    end

    // storage array
    // write enable takes the place of a gated clock
    always_ff @(posedge clk_i) begin
        if (mem_we) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

/* src/spm_bank.sv */
module spm_bank
    import spm_cfg_pkg::*;
    import spm_types_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 flush_i,
    // request fifo side
    input  spm_req_t             req_i,
    input  logic                 req_empty_i,
    output logic                 req_pop_o,
    // response fifo side
    input  logic                 rsp_full_i,
    input  logic [rsp_cnt_w-1:0] rsp_usage_i,
    output spm_rsp_t             rsp_o,
    output logic                 rsp_push_o
);

    // scratchpad array, contents survive reset and flush
    logic [spm_data_w-1:0] mem_q [spm_words];

    // load result register and its valid flag
    spm_rsp_t              rsp_q;
    logic                  pend_q;

    // head request decode
    logic                  head_is_load;
    logic                  head_is_store;
    // response fifo can take one more result behind any pending one
    logic                  load_ok;
    // accepted pops by kind
    logic                  do_load;
    logic                  do_store;

    assign head_is_load  = !req_empty_i && (req_i.op == op_load);
    assign head_is_store = !req_empty_i && (req_i.op == op_store);

    // admission for loads
    // no pending result: one free slot is enough
    // pending result: it takes a slot next cycle, so the fifo must be empty now
    // usage wraps to zero when full, hence the extra full check
    always_comb begin
        if (pend_q) begin
            load_ok = !rsp_full_i && (rsp_usage_i == '0);
        end else begin
            load_ok = !rsp_full_i;
        end
    end

    // stores never stall, loads wait for room in the response fifo
    // a stalled load also holds back everything behind it
    assign do_store  = head_is_store;
    assign do_load   = head_is_load && load_ok;
    assign req_pop_o = do_store || do_load;

    // store path
    // write lands at the pop edge, except when a flush drops the request
    always_ff @(posedge clk_i) begin
        if (do_store && !flush_i) begin
            mem_q[req_i.addr] <= req_i.payload.wdata;
        end
    end

    // load path
    // synchronous read into the result register
    // tag comes from the load view of the payload
    always_ff @(posedge clk_i) begin
        if (do_load) begin
            rsp_q.data <= mem_q[req_i.addr];
            rsp_q.tag  <= req_i.payload.ld.tag;
        end
    end

    // pending flag
    // set by an accepted load, held only one cycle since the push is never refused
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pend_q <= 1'b0;
        end else if (flush_i) begin
            // load in flight is cancelled, a load popped now is dropped too
            pend_q <= 1'b0;
        end else begin
            pend_q <= do_load;
        end
    end

    // result goes to the response fifo one cycle after the read
    assign rsp_push_o = pend_q;
    assign rsp_o      = rsp_q;

endmodule

/* src/spm_queue_top.sv */
module spm_queue_top
    import spm_cfg_pkg::*;
    import spm_types_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     flush_i,
    // requester push side
    input  spm_req_t req_i,
    input  logic     req_push_i,
    output logic     req_ready_o,
    // requester pop side
    output spm_rsp_t rsp_o,
    output logic     rsp_valid_o,
    input  logic     rsp_pop_i
);

    // request fifo to bank
    spm_req_t             req_head;
    logic                 req_empty;
    logic                 req_full;
    logic                 req_pop;

    // bank to response fifo
    spm_rsp_t             bank_rsp;
    logic                 rsp_push;
    logic                 rsp_full;
    logic                 rsp_empty;
    logic [rsp_cnt_w-1:0] rsp_usage;

    // levels seen by the requester
    assign req_ready_o = !req_full;
    assign rsp_valid_o = !rsp_empty;

    // fall-through so a request reaches the bank in the cycle it arrives
    fifo_v3 #(
        .FALL_THROUGH (1'b1),
        .DEPTH        (req_depth),
        .dtype        (spm_req_t)
    ) req_fifo_inst (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .flush_i (flush_i),
        .full_o  (req_full),
        .empty_o (req_empty),
        // fill level not needed on this side
        .usage_o (),
        .data_i  (req_i),
        .push_i  (req_push_i),
        .data_o  (req_head),
        .pop_i   (req_pop)
    );

    spm_bank spm_bank_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .req_i       (req_head),
        .req_empty_i (req_empty),
        .req_pop_o   (req_pop),
        .rsp_full_i  (rsp_full),
        .rsp_usage_i (rsp_usage),
        .rsp_o       (bank_rsp),
        .rsp_push_o  (rsp_push)
    );

    // normal mode, results become visible one edge after the push
    fifo_v3 #(
        .FALL_THROUGH (1'b0),
        .DEPTH        (rsp_depth),
        .dtype        (spm_rsp_t)
    ) rsp_fifo_inst (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .flush_i (flush_i),
        .full_o  (rsp_full),
        .empty_o (rsp_empty),
        .usage_o (rsp_usage),
        .data_i  (bank_rsp),
        .push_i  (rsp_push),
        .data_o  (rsp_o),
        .pop_i   (rsp_pop_i)
    );

endmodule

/* dv/spm_queue_tb.sv */
module spm_queue_tb
    import spm_cfg_pkg::*;
    import spm_types_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    // cycles any single wait may take before it gives up
    localparam int unsigned wait_limit = 500;

    logic     clk_i;
    logic     rst_i;
    logic     flush_i;
    spm_req_t req_i;
    logic     req_push_i;
    logic     req_ready_o;
    spm_rsp_t rsp_o;
    logic     rsp_valid_o;
    logic     rsp_pop_i;

    // model memory, updated in acceptance order
    logic [spm_data_w-1:0] model_mem [spm_words];
    // expected load results, oldest first
    spm_rsp_t              exp_q [$];
    int unsigned           errors;
    int unsigned           rsp_count;
    string                 test_name;

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    spm_queue_top spm_queue_top_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .req_i       (req_i),
        .req_push_i  (req_push_i),
        .req_ready_o (req_ready_o),
        .rsp_o       (rsp_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_pop_i   (rsp_pop_i)
    );

    // a load returns the word at its address and the tag it carried
    function automatic spm_rsp_t expect_load(input spm_req_t r,
                                             input logic [spm_data_w-1:0] mem [spm_words]);
        spm_rsp_t rsp;
        rsp.tag  = r.payload.ld.tag;
        rsp.data = mem[r.addr];
        return rsp;
    endfunction

    function automatic spm_req_t make_load(input logic [spm_addr_w-1:0] addr,
                                           input logic [spm_tag_w-1:0] tag);
        spm_req_t r;
        r.op               = op_load;
        r.addr             = addr;
        r.payload.wdata    = '0;
        r.payload.ld.tag   = tag;
        return r;
    endfunction

    function automatic spm_req_t make_store(input logic [spm_addr_w-1:0] addr,
                                            input logic [spm_data_w-1:0] data);
        spm_req_t r;
        r.op            = op_store;
        r.addr          = addr;
        r.payload.wdata = data;
        return r;
    endfunction

    // one clock cycle, entered and left 1 ns after a rising edge
    // ready only moves at edges, so sampling it here matches the edge
    task automatic step(input logic push, input spm_req_t r);
        logic acc;
        req_i      = r;
        req_push_i = push;
        acc        = push && req_ready_o;
        @(posedge clk_i);
        if (acc) begin
            if (r.op == op_store) begin
                model_mem[r.addr] = r.payload.wdata;
            end else begin
                exp_q.push_back(expect_load(r, model_mem));
            end
        end
        #1;
        req_push_i = 1'b0;
    endtask

    task automatic idle();
        step(1'b0, '0);
    endtask

    // waits for a free request slot, then pushes
    task automatic push_req(input spm_req_t r);
        int unsigned waited;
        waited = 0;
        while (!req_ready_o && waited < wait_limit) begin
            idle();
            waited++;
        end
        if (!req_ready_o) begin
            $display("request queue never became ready during %s", test_name);
            errors++;
        end else begin
            step(1'b1, r);
        end
    endtask

    // all expected responses popped and checked
    task automatic wait_empty();
        int unsigned waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < wait_limit) begin
            idle();
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d responses never arrived during %s", exp_q.size(), test_name);
            errors++;
        end
    endtask

    // marker load behind everything queued
    // its response means every earlier store has been written
    task automatic drain();
        rsp_pop_i = 1'b1;
        push_req(make_load('0, '1));
        wait_empty();
    endtask

    task automatic wait_not_ready();
        int unsigned waited;
        waited = 0;
        while (req_ready_o && waited < wait_limit) begin
            idle();
            waited++;
        end
        if (req_ready_o) begin
            $display("request queue never filled up during %s", test_name);
            errors++;
        end
    endtask

    // one flush cycle, every queued or in-flight load is gone afterwards
    task automatic do_flush();
        flush_i = 1'b1;
        @(posedge clk_i);
        exp_q.delete();
        #1;
        flush_i = 1'b0;
    endtask

    // response checker, one compare per popped response
    always @(posedge clk_i) begin
        spm_rsp_t exp_rsp;
        if (!rst_i && rsp_valid_o && rsp_pop_i) begin
            if (exp_q.size() == 0) begin
                $display("response with tag %h data %h arrived with none expected in %s",
                         rsp_o.tag, rsp_o.data, test_name);
                errors++;
            end else begin
                exp_rsp = exp_q.pop_front();
                rsp_count++;
                if (rsp_o !== exp_rsp) begin
                    $display("[FAIL] %s: expected tag %h data %h, actual tag %h data %h",
                             test_name, exp_rsp.tag, exp_rsp.data, rsp_o.tag, rsp_o.data);
                    errors++;
                end
            end
        end
    end

    initial begin
        spm_req_t    r;
        logic [31:0] rnd;
        int unsigned base;
        int unsigned nload;
        errors     = 0;
        rsp_count  = 0;
        test_name  = "reset";
        rnd        = $urandom(32'hcac0);
        rst_i      = 1'b1;
        flush_i    = 1'b0;
        req_i      = '0;
        req_push_i = 1'b0;
        rsp_pop_i  = 1'b0;
        for (int i = 0; i < spm_words; i++) begin
            model_mem[i] = '0;
        end
        repeat (16) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        if (!req_ready_o) begin
            $display("[FAIL] %s: expected req_ready_o 1, actual %b", test_name, req_ready_o);
            errors++;
        end
        if (rsp_valid_o) begin
            $display("[FAIL] %s: expected rsp_valid_o 0, actual %b", test_name, rsp_valid_o);
            errors++;
        end

        // odd multiplier keeps every written word distinct
        test_name = "store_load";
        rsp_pop_i = 1'b1;
        for (int i = 0; i < spm_words; i++) begin
            push_req(make_store(i[spm_addr_w-1:0], 32'(i) * 32'h9e3779b9 + 32'h12345678));
        end
        for (int i = 0; i < spm_words; i++) begin
            push_req(make_load(i[spm_addr_w-1:0], i[spm_tag_w-1:0]));
        end
        wait_empty();

        // eight addresses only, so loads often hit a store just before them
        test_name = "mix";
        for (int i = 0; i < 300; i++) begin
            rnd = $urandom;
            if (rnd[0]) begin
                r = make_store(spm_addr_w'(rnd[3:1]), $urandom);
            end else begin
                r = make_load(spm_addr_w'(rnd[3:1]), rnd[7:4]);
            end
            push_req(r);
        end
        wait_empty();

        test_name = "backpressure";
        rsp_pop_i = 1'b0;
        base      = rsp_count;
        for (int i = 0; i < 6; i++) begin
            push_req(make_load(spm_addr_w'(i + 20), spm_tag_w'(i + 3)));
        end
        wait_not_ready();
        rsp_pop_i = 1'b1;
        wait_empty();
        if (rsp_count - base != 6) begin
            $display("[FAIL] %s: expected 6 responses, actual %0d", test_name, rsp_count - base);
            errors++;
        end

        test_name = "flush";
        rsp_pop_i = 1'b1;
        for (int i = 0; i < 4; i++) begin
            push_req(make_store(spm_addr_w'(i + 8), 32'hf1a50000 + 32'(i)));
        end
        drain();
        rsp_pop_i = 1'b0;
        // enough loads to fill both queues, so ready is low going into the flush
        for (int i = 0; i < 6; i++) begin
            push_req(make_load(spm_addr_w'(i + 8), spm_tag_w'(i + 9)));
        end
        wait_not_ready();
        idle();
        idle();
        do_flush();
        if (rsp_valid_o) begin
            $display("[FAIL] %s: expected rsp_valid_o 0, actual %b", test_name, rsp_valid_o);
            errors++;
        end
        if (!req_ready_o) begin
            $display("[FAIL] %s: expected req_ready_o 1, actual %b", test_name, req_ready_o);
            errors++;
        end
        rsp_pop_i = 1'b1;
        for (int i = 0; i < 4; i++) begin
            push_req(make_load(spm_addr_w'(i + 8), spm_tag_w'(i + 1)));
        end
        wait_empty();

        // a flush follows a drain and a few loads only
        // so no unexecuted store is ever dropped
        test_name = "soak";
        for (int c = 0; c < 2000; c++) begin
            rnd = $urandom;
            if (rnd[7:0] == 8'd0) begin
                drain();
                rsp_pop_i = 1'b0;
                nload     = 32'(rnd[9:8]) + 1;
                for (int k = 0; k < nload; k++) begin
                    push_req(make_load(rnd[spm_addr_w+12:13], rnd[spm_tag_w+20:21]));
                end
                do_flush();
            end else begin
                rsp_pop_i       = rnd[10] | rnd[11];
                r.op            = spm_op_e'(rnd[12]);
                r.addr          = rnd[spm_addr_w+12:13];
                r.payload.wdata = $urandom;
                step(rnd[20] && req_ready_o, r);
            end
        end
        drain();
        // nothing may be left behind the marker once it has been popped
        rsp_pop_i = 1'b0;
        repeat (4) idle();
        if (rsp_valid_o) begin
            $display("[FAIL] %s: expected rsp_valid_o 0, actual %b", test_name, rsp_valid_o);
            errors++;
        end

        $display("run complete with %0d errors over %0d responses", errors, rsp_count);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* vlog.f */
src/spm_cfg_pkg.sv
src/spm_types_pkg.sv
src/fifo_v3.sv
src/spm_bank.sv
src/spm_queue_top.sv
dv/spm_queue_tb.sv

/* Makefile */
# Verilator build and run of the scratchpad queue testbench

SIM      = verilator
SIMFLAGS = --binary --timing --timescale 1ns/100ps -j 0
TOP      = spm_queue_tb
FILELIST = vlog.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = No errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# pass or fail comes from the log, not from the simulator exit code
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
